//--- Makefile
TOP = ftoi_unit_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing -Wno-fatal -f sim.f --top-module $(TOP) -Mdir obj_dir
	obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^Regression passed$$"

clean:
	rm -rf obj_dir

//--- conv_station.sv
module conv_station #(
	parameter int n_entry = 2
) (
	input logic clk,
	input logic reset,

	input logic issue_valid,
	input ooo_pkg::rob_tag_t issue_tag,
	input ooo_pkg::cdb_t issue_opd,
	output logic issue_ready,

	input ooo_pkg::cdb_t fpr_cdb,

	output logic disp_valid,
	output ooo_pkg::rob_tag_t disp_tag,
	output fp_pkg::fp_word_t disp_data,
	input logic disp_ready
);
	import ooo_pkg::*;

	localparam int sel_w = $clog2(n_entry);

	typedef struct packed {
		logic valid;
		rob_tag_t tag;    // destination
		cdb_t opd;
	} entry_t;

	entry_t ent [n_entry];       // index 0 is the oldest
	entry_t woken [n_entry];
	entry_t shifted [n_entry];
	entry_t ent_next [n_entry];
	entry_t new_ent;

	logic [n_entry-1:0] rdy;
	logic [sel_w-1:0] sel;
	logic dispatch;
	logic accept;
	logic placed;

	// capture the operand if its producer is on the bus this cycle
	function automatic cdb_t wake(cdb_t opd, cdb_t bus);
		cdb_t res;
		res = opd;
		if (!opd.valid && bus.valid && bus.tag == opd.tag) begin
			res.valid = 1'b1;
			res.data = bus.data;
		end
		return res;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// wakeup and dispatch select
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		for (int i = 0; i < n_entry; i++) begin
			woken[i] = ent[i];
			woken[i].opd = wake(ent[i].opd, fpr_cdb);
			rdy[i] = ent[i].valid && ent[i].opd.valid;  // wakeup counts next cycle
		end
	end

	// lowest ready index wins
	always_comb begin
		sel = '0;
		for (int i = n_entry - 1; i >= 0; i--) begin
			if (rdy[i])
				sel = sel_w'(i);
		end
	end

	assign disp_valid = |rdy;
	assign disp_tag = ent[sel].tag;
	assign disp_data = ent[sel].opd.data;

	assign dispatch = disp_valid && disp_ready;
	assign issue_ready = !ent[n_entry-1].valid || dispatch;  // entries stay packed
	assign accept = issue_valid && issue_ready;

	always_comb begin
		new_ent.valid = 1'b1;
		new_ent.tag = issue_tag;
		new_ent.opd = wake(issue_opd, fpr_cdb);  // same cycle broadcast
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// compaction and fill
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		for (int i = 0; i < n_entry - 1; i++)
			shifted[i] = (dispatch && i >= sel) ? woken[i+1] : woken[i];
		shifted[n_entry-1] = dispatch ? '0 : woken[n_entry-1];

		placed = 1'b0;
		for (int i = 0; i < n_entry; i++) begin
			ent_next[i] = shifted[i];
			if (accept && !placed && !shifted[i].valid) begin
				ent_next[i] = new_ent;  // first free slot
				placed = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < n_entry; i++)
				ent[i].valid <= 1'b0;
		end else begin
			ent <= ent_next;
		end
	end

endmodule

//--- fp_pkg.sv
package fp_pkg;

	localparam int exp_bias = 127;

	// ieee single precision layout
	typedef struct packed {
		logic sign;
		logic [7:0] exp;
		logic [22:0] frac;
	} fp_word_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// decoded operand between the two converter stages
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef struct packed {
		ooo_pkg::rob_tag_t tag;
		logic sign;
		logic signed [8:0] exp;  // unbiased
		logic [23:0] mant;       // hidden one restored
		logic is_nan;
		logic too_big;           // magnitude >= 2^31
		logic is_small;          // magnitude < 0.5
	} ftoi_dec_t;

	// saturation limits
	localparam logic [31:0] int_max = 32'h7fff_ffff;
	localparam logic [31:0] int_min = 32'h8000_0000;

endpackage

//--- ftoi_cases.txt
// columns: operand bits (hex), expected integer (hex), group
// group 1 plain conversions, group 2 ties, limits, nan and tiny values
3f800000 00000001 1
00000000 00000000 1
42c80000 00000064 1
bf800000 ffffffff 1
40700000 00000004 1
c0100000 fffffffe 1
47f12000 0001e240 1
c47a0000 fffffc18 1
3f000000 00000000 2
3fc00000 00000002 2
40200000 00000002 2
bfc00000 fffffffe 2
4effffff 7fffff80 2
4f000000 7fffffff 2
cf000000 80000000 2
ff800000 80000000 2
7fc00000 7fffffff 2
3e800000 00000000 2
00000001 00000000 2

//--- ftoi_core.sv
module ftoi_core (
	input logic clk,
	input logic reset,

	input logic in_valid,
	input ooo_pkg::rob_tag_t in_tag,
	input fp_pkg::fp_word_t in_data,
	output logic in_ready,

	output logic out_valid,
	output ooo_pkg::gpr_wb_t out,
	input logic out_ready
);
	import ooo_pkg::*;
	import fp_pkg::*;

	ftoi_dec_t dec;
	ftoi_dec_t s1_out;
	logic s1_valid;
	logic s1_ready;

	gpr_wb_t conv;

	logic [5:0] sh;
	logic [63:0] fix;       // 32 integer bits, 32 fraction bits
	logic [31:0] int_part;
	logic [31:0] mag;
	logic guard;
	logic sticky;
	logic round_up;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// decode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		dec.tag = in_tag;
		dec.sign = in_data.sign;
		dec.exp = $signed({1'b0, in_data.exp}) - 9'(exp_bias);
		dec.mant = {in_data.exp != 8'd0, in_data.frac};
		dec.is_nan = (in_data.exp == 8'hff) && (in_data.frac != '0);
		dec.too_big = dec.exp >= 9'sd31;  // also catches infinity
		dec.is_small = dec.exp < -9'sd1;  // zero and denormals too
	end

	pipe_stage #(
		.payload_t(ftoi_dec_t)
	) stage1_i (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_data(dec),
		.in_ready(in_ready),
		.out_valid(s1_valid),
		.out_data(s1_out),
		.out_ready(s1_ready)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// shift, round, saturate
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		// exponent -1..30 maps to 8..39, leading one lands on bit 31..62
		sh = 6'(s1_out.exp + 9'sd9);
		fix = 64'(s1_out.mant) << sh;
		int_part = fix[63:32];
		guard = fix[31];
		sticky = |fix[30:0];
		round_up = guard && (sticky || int_part[0]);  // ties to even
		mag = int_part + 32'(round_up);

		conv.tag = s1_out.tag;
		if (s1_out.is_nan)
			conv.result = int_max;
		else if (s1_out.is_small)  // shift amount wraps for tiny exponents
			conv.result = '0;
		else if (s1_out.too_big || mag[31])  // mag[31] means rounded up to 2^31
			conv.result = s1_out.sign ? int_min : int_max;
		else
			conv.result = s1_out.sign ? 32'(0 - mag) : mag;
	end

	pipe_stage #(
		.payload_t(gpr_wb_t)
	) stage2_i (
		.clk(clk),
		.reset(reset),
		.in_valid(s1_valid),
		.in_data(conv),
		.in_ready(s1_ready),
		.out_valid(out_valid),
		.out_data(out),
		.out_ready(out_ready)
	);

endmodule

//--- ftoi_unit.sv
module ftoi_unit #(
	parameter int rob_width = ooo_pkg::rob_width,
	parameter int n_entry = 2
) (
	input logic clk,
	input logic reset,

	input logic issue_valid,
	input ooo_pkg::rob_tag_t issue_tag,
	input ooo_pkg::cdb_t issue_opd,
	output logic issue_ready,

	input ooo_pkg::cdb_t fpr_cdb,

	output logic wb_valid,
	output ooo_pkg::gpr_wb_t wb,
	input logic wb_ready
);
	import fp_pkg::*;

	// station to converter
	logic disp_valid;
	logic disp_ready;
	logic [rob_width-1:0] disp_tag;
	fp_word_t disp_data;

	conv_station #(
		.n_entry(n_entry)
	) conv_station_i (
		.clk(clk),
		.reset(reset),
		.issue_valid(issue_valid),
		.issue_tag(issue_tag),
		.issue_opd(issue_opd),
		.issue_ready(issue_ready),
		.fpr_cdb(fpr_cdb),
		.disp_valid(disp_valid),
		.disp_tag(disp_tag),
		.disp_data(disp_data),
		.disp_ready(disp_ready)
	);

	ftoi_core ftoi_core_i (
		.clk(clk),
		.reset(reset),
		.in_valid(disp_valid),
		.in_tag(disp_tag),
		.in_data(disp_data),
		.in_ready(disp_ready),
		.out_valid(wb_valid),
		.out(wb),
		.out_ready(wb_ready)
	);

endmodule

//--- ftoi_unit_tb.sv
module ftoi_unit_tb;
	import ooo_pkg::*;
	import fp_pkg::*;

	localparam int n_entry = 2;
	localparam int n_tag = 1 << rob_width;
	localparam int max_case = 64;
	localparam int timeout = 200;  // cycles

	logic clk;
	logic reset;
	logic issue_valid;
	rob_tag_t issue_tag;
	cdb_t issue_opd;
	logic issue_ready;
	cdb_t fpr_cdb;
	logic wb_valid;
	gpr_wb_t wb;
	logic wb_ready;

	logic [31:0] case_opd [max_case];
	logic [31:0] case_exp [max_case];
	int case_grp [max_case];
	int n_case;

	// scoreboard by destination tag
	logic [31:0] exp_val [n_tag];
	int issued [n_tag];
	int seen [n_tag];
	rob_tag_t next_tag;
	rob_tag_t last_tag;
	int received;
	int errors;
	int checks;
	int n_test;
	int test_err;
	int stall_mode;  // 0 ready, 1 held low, 2 random
	integer seed;

	ftoi_unit #(
		.rob_width(rob_width),
		.n_entry(n_entry)
	) ftoi_unit_i (
		.clk(clk),
		.reset(reset),
		.issue_valid(issue_valid),
		.issue_tag(issue_tag),
		.issue_opd(issue_opd),
		.issue_ready(issue_ready),
		.fpr_cdb(fpr_cdb),
		.wb_valid(wb_valid),
		.wb(wb),
		.wb_ready(wb_ready)
	);

	always #20 clk = ~clk;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// compare tasks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic check_wb(gpr_wb_t got);
		checks++;
		if (issued[got.tag] == seen[got.tag]) begin
			$display("result for tag %0d at %0t was never issued or came twice", got.tag, $time);
			errors++;
		end else begin
			seen[got.tag]++;
			if (got.result !== exp_val[got.tag]) begin
				$display("FAIL %0t: tag %0d result %h, expected %h", $time, got.tag,
					got.result, exp_val[got.tag]);
				errors++;
			end
		end
		last_tag = got.tag;
		received++;
	endtask

	task automatic check_level(logic got, logic want, string what);
		checks++;
		if (got !== want) begin
			$display("FAIL %0t: %s is %b, expected %b", $time, what, got, want);
			errors++;
		end
	endtask

	task automatic check_tag(rob_tag_t got, rob_tag_t want, string what);
		checks++;
		if (got !== want) begin
			$display("FAIL %0t: %s has tag %0d, expected %0d", $time, what, got, want);
			errors++;
		end
	endtask

	// results are taken mid-cycle, the handshake completes on the next edge
	always @(negedge clk) begin
		if (!reset && wb_valid && wb_ready)
			check_wb(wb);
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic load_cases();
		int fd;
		string line;
		logic [31:0] opd;
		logic [31:0] expv;
		int grp;
		n_case = 0;
		fd = $fopen("ftoi_cases.txt", "r");
		if (fd == 0) begin
			$display("cannot open ftoi_cases.txt");
			errors++;
			return;
		end
		while (!$feof(fd) && n_case < max_case) begin
			if ($fgets(line, fd) > 0 && $sscanf(line, "%h %h %d", opd, expv, grp) == 3) begin
				case_opd[n_case] = opd;
				case_exp[n_case] = expv;
				case_grp[n_case] = grp;
				n_case++;
			end
		end
		$fclose(fd);
		if (n_case < 3) begin
			$display("too few cases in ftoi_cases.txt");
			errors++;
		end
	endtask

	// next edge, then drive wb_ready
	task automatic step();
		@(posedge clk);
		#2;
		if (stall_mode == 2)
			wb_ready = ($random(seed) & 3) != 0;
		else
			wb_ready = (stall_mode == 0);
	endtask

	function automatic int in_flight();
		int sum;
		sum = 0;
		for (int t = 0; t < n_tag; t++)
			sum += issued[t] - seen[t];
		return sum;
	endfunction

	// a held operand waits on producer tag ~tag
	task automatic issue_op(logic [31:0] bits, logic [31:0] expv, logic hold, int patience,
			output rob_tag_t tag, output logic ok);
		int n;
		n = 0;
		tag = next_tag;
		ok = 1'b0;
		while (issued[next_tag] != seen[next_tag] && n < timeout) begin
			step();
			n++;
		end
		if (issued[next_tag] != seen[next_tag]) begin
			$display("timeout: tag %0d never came back, cannot reuse it", next_tag);
			errors++;
			return;
		end
		issue_valid = 1'b1;
		issue_tag = tag;
		issue_opd.valid = !hold;
		issue_opd.tag = ~tag;
		issue_opd.data = hold ? 32'h0 : bits;
		n = 0;
		@(negedge clk);
		while (!issue_ready && n < patience) begin
			@(negedge clk);
			n++;
		end
		ok = issue_ready;
		if (ok) begin
			exp_val[tag] = expv;
			issued[tag]++;
			next_tag++;
		end
		step();  // accepted on this edge
		issue_valid = 1'b0;
	endtask

	task automatic broadcast(rob_tag_t prod, logic [31:0] bits);
		fpr_cdb.valid = 1'b1;
		fpr_cdb.tag = prod;
		fpr_cdb.data = bits;
		step();
		fpr_cdb = '0;
	endtask

	task automatic wait_received(int target);
		int n;
		n = 0;
		while (received < target && n < timeout) begin
			step();
			n++;
		end
		if (received < target) begin
			$display("timeout: no result came out within %0d cycles", timeout);
			errors++;
		end
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (in_flight() != 0 && n < timeout) begin
			step();
			n++;
		end
		if (in_flight() != 0) begin
			$display("timeout: %0d results still missing", in_flight());
			errors++;
		end
	endtask

	task automatic run_group(int grp);
		rob_tag_t tag;
		logic hold;
		logic ok;
		for (int i = 0; i < n_case; i++) begin
			if (case_grp[i] == grp) begin
				hold = (grp == 2) && (($random(seed) & 3) == 0);
				issue_op(case_opd[i], case_exp[i], hold, timeout, tag, ok);
				if (!ok) begin
					$display("timeout: issue_ready stayed low for case %0d", i);
					errors++;
				end else if (hold) begin
					broadcast(~tag, case_opd[i]);
				end
			end
		end
		wait_drain();
	endtask

	task automatic end_test(string name);
		n_test++;
		if (errors == test_err)
			$display("test %0d %s: ok", n_test, name);
		else
			$display("test %0d %s: %0d errors", n_test, name, errors - test_err);
		test_err = errors;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// test sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		rob_tag_t tag_a;
		rob_tag_t tag_b;
		logic ok;
		int accepted;
		int r0;
		seed = 90;
		clk = 1'b0;
		reset = 1'b1;
		issue_valid = 1'b0;
		issue_tag = '0;
		issue_opd = '0;
		fpr_cdb = '0;
		wb_ready = 1'b1;
		stall_mode = 0;
		next_tag = '0;
		last_tag = '0;
		received = 0;
		errors = 0;
		checks = 0;
		n_test = 0;
		for (int t = 0; t < n_tag; t++) begin
			issued[t] = 0;
			seen[t] = 0;
		end
		load_cases();
		test_err = errors;
		repeat (4) @(posedge clk);
		#2;
		reset = 1'b0;

		@(negedge clk);
		check_level(issue_ready, 1'b1, "issue_ready after reset");
		check_level(wb_valid, 1'b0, "wb_valid after reset");
		step();
		end_test("reset state");

		run_group(1);
		end_test("ready operands");
		run_group(2);
		end_test("rounding and saturation");

		// older instruction waits on its producer, younger one passes it
		r0 = received;
		issue_op(case_opd[2], case_exp[2], 1'b1, timeout, tag_a, ok);
		if (!ok) begin
			$display("timeout: issue_ready stayed low for the waiting instruction");
			errors++;
		end
		issue_op(case_opd[0], case_exp[0], 1'b0, timeout, tag_b, ok);
		if (!ok) begin
			$display("timeout: issue_ready stayed low for the ready instruction");
			errors++;
		end
		wait_received(r0 + 1);
		check_tag(last_tag, tag_b, "first result");
		broadcast(~tag_a, case_opd[2]);
		wait_drain();
		end_test("wakeup and order");

		stall_mode = 1;
		wb_ready = 1'b0;
		accepted = 0;
		ok = 1'b1;
		while (ok && accepted <= n_entry + 2) begin
			issue_op(case_opd[accepted % n_case], case_exp[accepted % n_case], 1'b0, 0,
				tag_a, ok);
			if (ok)
				accepted++;
		end
		if (accepted > n_entry + 2) begin
			$display("issue_ready still high after %0d accepted instructions", accepted);
			errors++;
		end
		@(negedge clk);
		check_level(issue_ready, 1'b0, "issue_ready when full");
		check_level(wb_valid, 1'b1, "wb_valid while stalled");
		stall_mode = 2;
		step();
		wait_drain();
		end_test("back-pressure");

		$display("%0d tests, %0d checks, %0d errors", n_test, checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

//--- ooo_pkg.sv
package ooo_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reorder buffer tags
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int rob_width = 4;  // default for the top level

	typedef logic [rob_width-1:0] rob_tag_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// common data bus payloads
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// tagged operand
	// valid high means data holds the value, otherwise wait for tag on the bus
	typedef struct packed {
		logic valid;
		rob_tag_t tag;    // producer tag while waiting
		logic [31:0] data;
	} cdb_t;

	// integer result headed for the integer bus
	typedef struct packed {
		rob_tag_t tag;    // destination rob slot
		logic [31:0] result;
	} gpr_wb_t;

endpackage

//--- pipe_stage.sv
module pipe_stage #(
	parameter type payload_t = logic
) (
	input logic clk,
	input logic reset,

	input logic in_valid,
	input payload_t in_data,
	output logic in_ready,

	output logic out_valid,
	output payload_t out_data,
	input logic out_ready
);

	logic full;
	payload_t data_q;

	// take new data when empty or when the current item leaves now
	assign in_ready = !full || out_ready;

	always_ff @(posedge clk) begin
		if (reset)
			full <= 1'b0;
		else if (in_ready)
			full <= in_valid;
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready)
			data_q <= in_data;
	end

	assign out_valid = full;
	assign out_data = data_q;

endmodule

//--- sim.f
ooo_pkg.sv
fp_pkg.sv
pipe_stage.sv
conv_station.sv
ftoi_core.sv
ftoi_unit.sv
ftoi_unit_tb.sv
